// ==== verilog/tinker_pkg.sv ====
//####################################################################
// Tinker types, opcode numbering and instruction field positions
// Opcodes of dropped instructions keep their numbers and act as no-ops
//####################################################################

package tinker_pkg;

    typedef logic [63:0] word_t;       // Data, addresses and PC
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] literal_t;

    typedef enum logic [4:0] {
        op_and     = 5'd0,  op_or      = 5'd1,  op_xor     = 5'd2,  op_not     = 5'd3,
        op_shftr   = 5'd4,  op_shftri  = 5'd5,  op_shftl   = 5'd6,  op_shftli  = 5'd7,
        op_br      = 5'd8,  op_brr     = 5'd9,  op_brri    = 5'd10, op_brnz    = 5'd11,
        op_call    = 5'd12, op_return  = 5'd13, op_brgt    = 5'd14, op_priv    = 5'd15,
        op_mov_mem = 5'd16, op_mov_reg = 5'd17, op_mov_lit = 5'd18, op_mov_str = 5'd19,
        op_addf    = 5'd20, op_subf    = 5'd21, op_mulf    = 5'd22, op_divf    = 5'd23,
        op_add     = 5'd24, op_addi    = 5'd25, op_sub     = 5'd26, op_subi    = 5'd27,
        op_mul     = 5'd28, op_div     = 5'd29
    } opcode_t;

    // Instruction fields
    localparam int op_msb  = 31;
    localparam int op_lsb  = 27;
    localparam int rd_msb  = 26;
    localparam int rd_lsb  = 22;
    localparam int rs_msb  = 21;
    localparam int rs_lsb  = 17;
    localparam int rt_msb  = 16;
    localparam int rt_lsb  = 12;
    localparam int lit_msb = 11;
    localparam int lit_lsb = 0;

    // Priv with a nonzero literal, used as the pipeline bubble
    localparam inst_t nop_inst = {op_priv, 15'd0, 12'd1};

    // Opcodes whose second operand is the literal instead of rt
    function automatic logic uses_literal(opcode_t op);
        return op inside {op_addi, op_subi, op_shftri, op_shftli, op_brri,
                          op_mov_mem, op_mov_lit, op_mov_str};
    endfunction

endpackage

// ==== verilog/tinker_fetch.sv ====
//####################################################################
// PC and IF/DE register; a taken branch bubbles the slot in decode
//####################################################################

`timescale 1ns/10ps

module tinker_fetch #(
    parameter tinker_pkg::word_t reset_pc = 64'h2000
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               branch_taken,
    input  tinker_pkg::word_t  branch_pc,
    input  tinker_pkg::inst_t  inst,
    output tinker_pkg::word_t  fetch_pc,
    output tinker_pkg::word_t  de_pc,
    output tinker_pkg::inst_t  de_inst
);
    import tinker_pkg::*;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            fetch_pc <= reset_pc;
        else if (branch_taken)
            fetch_pc <= branch_pc;      // Redirect from MEM
        else
            fetch_pc <= fetch_pc + 64'd4;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            de_inst <= nop_inst;
        else
            de_inst <= branch_taken ? nop_inst : inst;
    end

    always_ff @(posedge clk) begin
        de_pc <= fetch_pc;
    end

endmodule

// ==== verilog/tinker_regfile.sv ====
//####################################################################
// 32 x 64-bit registers, R0 writable; reads bypass the current write
//####################################################################

`timescale 1ns/10ps

module tinker_regfile (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   write_en,
    input  tinker_pkg::reg_addr_t  write_rd,
    input  tinker_pkg::word_t      write_data,
    input  tinker_pkg::reg_addr_t  rs,
    input  tinker_pkg::reg_addr_t  rt,
    input  tinker_pkg::reg_addr_t  rd,
    output tinker_pkg::word_t      rs_data,
    output tinker_pkg::word_t      rt_data,
    output tinker_pkg::word_t      rd_data
);
    import tinker_pkg::*;

    word_t     regs [32];
    reg_addr_t raddr [3];
    word_t     rdata [3];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (write_en) begin
            regs[write_rd] <= write_data;
        end
    end

    assign raddr = '{rs, rt, rd};

    // Write-through so decode sees a value retiring in this cycle
    for (genvar p = 0; p < 3; p++) begin : g_read
        assign rdata[p] = (write_en && write_rd == raddr[p]) ? write_data : regs[raddr[p]];
    end

    assign rs_data = rdata[0];
    assign rt_data = rdata[1];
    assign rd_data = rdata[2];

endmodule

// ==== verilog/tinker_decode.sv ====
//####################################################################
// Field split, operand select and DE/EX register
// Literal is zero-extended; immediate forms read their rs from rd
//####################################################################

`timescale 1ns/10ps

module tinker_decode (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   branch_taken,
    input  tinker_pkg::word_t      de_pc,
    input  tinker_pkg::inst_t      de_inst,
    input  tinker_pkg::word_t      rs_data,
    input  tinker_pkg::word_t      rt_data,
    input  tinker_pkg::word_t      rd_data,
    output tinker_pkg::reg_addr_t  rs,
    output tinker_pkg::reg_addr_t  rt,
    output tinker_pkg::reg_addr_t  rd,
    output tinker_pkg::word_t      ex_pc,
    output tinker_pkg::opcode_t    ex_op,
    output tinker_pkg::word_t      ex_a,
    output tinker_pkg::word_t      ex_b,
    output tinker_pkg::word_t      ex_c,
    output tinker_pkg::word_t      ex_literal,
    output tinker_pkg::reg_addr_t  ex_rd,
    output tinker_pkg::reg_addr_t  ex_rs,
    output tinker_pkg::reg_addr_t  ex_rt,
    output logic                   ex_reg_write,
    output logic                   ex_mem_read,
    output logic                   ex_mem_write,
    output logic                   ex_valid_op
);
    import tinker_pkg::*;

    opcode_t   op;
    reg_addr_t rs_field;
    literal_t  lit;
    word_t     lit_ext;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic      valid_op;

    assign op       = opcode_t'(de_inst[op_msb:op_lsb]);
    assign rd       = de_inst[rd_msb:rd_lsb];
    assign rs_field = de_inst[rs_msb:rs_lsb];
    assign rt       = de_inst[rt_msb:rt_lsb];
    assign lit      = de_inst[lit_msb:lit_lsb];
    assign lit_ext  = word_t'(lit);

    // Immediate forms operate on rd in place
    assign rs = (op inside {op_addi, op_subi, op_shftri, op_shftli, op_mov_lit}) ? rd : rs_field;

    // ################################################################
    // Control per opcode
    // ################################################################
    always_comb begin
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        valid_op  = 1'b0;
        case (op)
            op_add, op_addi, op_sub, op_subi, op_mul, op_div,
            op_and, op_or, op_xor, op_not,
            op_shftr, op_shftri, op_shftl, op_shftli,
            op_mov_reg, op_mov_lit: begin
                reg_write = 1'b1;
                valid_op  = 1'b1;
            end
            op_mov_mem: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                valid_op  = 1'b1;
            end
            op_mov_str: begin
                mem_write = 1'b1;
                valid_op  = 1'b1;
            end
            op_br, op_brr, op_brri, op_brnz, op_brgt:
                valid_op = 1'b1;
            op_priv:
                valid_op = (lit == '0);     // Halt only
            default: ;                      // Float, call, return
        endcase
    end

    // ################################################################
    // DE/EX register
    // ################################################################
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            {ex_reg_write, ex_mem_read, ex_mem_write, ex_valid_op} <= '0;
        else if (branch_taken)
            {ex_reg_write, ex_mem_read, ex_mem_write, ex_valid_op} <= '0;
        else
            {ex_reg_write, ex_mem_read, ex_mem_write, ex_valid_op} <=
                {reg_write, mem_read, mem_write, valid_op};
    end

    always_ff @(posedge clk) begin
        ex_pc      <= de_pc;
        ex_op      <= op;
        ex_a       <= rs_data;
        ex_b       <= uses_literal(op) ? lit_ext : rt_data;
        ex_c       <= rd_data;
        ex_literal <= lit_ext;
        ex_rd      <= rd;
        ex_rs      <= rs;
        ex_rt      <= rt;
    end

endmodule

// ==== verilog/tinker_execute.sv ====
//####################################################################
// Forwarding, integer ALU, branch resolution and EX/MEM register
// Branches resolve here but take effect from MEM, one cycle later
//####################################################################

`timescale 1ns/10ps

module tinker_execute (
    input  logic                   clk,
    input  logic                   reset,
    input  tinker_pkg::word_t      ex_pc,
    input  tinker_pkg::opcode_t    ex_op,
    input  tinker_pkg::word_t      ex_a,
    input  tinker_pkg::word_t      ex_b,
    input  tinker_pkg::word_t      ex_c,
    input  tinker_pkg::word_t      ex_literal,
    input  tinker_pkg::reg_addr_t  ex_rd,
    input  tinker_pkg::reg_addr_t  ex_rs,
    input  tinker_pkg::reg_addr_t  ex_rt,
    input  logic                   ex_reg_write,
    input  logic                   ex_mem_read,
    input  logic                   ex_mem_write,
    input  logic                   ex_valid_op,
    input  tinker_pkg::word_t      wb_data,
    output tinker_pkg::word_t      mem_result,
    output tinker_pkg::word_t      mem_addr,
    output tinker_pkg::word_t      mem_wdata,
    output tinker_pkg::reg_addr_t  mem_rd,
    output logic                   mem_reg_write,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic                   branch_taken,
    output tinker_pkg::word_t      branch_pc,
    output logic                   hlt
);
    import tinker_pkg::*;

    word_t a;
    word_t b;
    word_t c;
    word_t result;
    word_t addr;
    word_t wdata;
    word_t target;
    logic  cond;
    logic  take;
    logic  halt;

    // ################################################################
    // MEM to EX forwarding on rs, rt and rd
    // ################################################################
    assign a = (mem_reg_write && mem_rd == ex_rs) ? wb_data : ex_a;
    assign c = (mem_reg_write && mem_rd == ex_rd) ? wb_data : ex_c;
    assign b = (!uses_literal(ex_op) && mem_reg_write && mem_rd == ex_rt) ? wb_data : ex_b;

    always_comb begin
        result = '0;
        addr   = '0;
        wdata  = '0;
        target = ex_pc + 64'd4;
        cond   = 1'b0;
        case (ex_op)
            op_add, op_addi:     result = a + b;
            op_sub, op_subi:     result = a - b;
            op_mul:              result = word_t'($signed(a) * $signed(b));
            op_div:              result = (b == '0) ? '0 : word_t'($signed(a) / $signed(b));
            op_and:              result = a & b;
            op_or:               result = a | b;
            op_xor:              result = a ^ b;
            op_not:              result = ~a;
            op_shftr, op_shftri: result = a >> b[5:0];
            op_shftl, op_shftli: result = a << b[5:0];
            op_mov_reg:          result = a;
            op_mov_lit:          result = {a[63:12], b[11:0]};   // Replace low 12 bits
            op_mov_mem:          addr = a + b;
            op_mov_str: begin
                addr  = c + ex_literal;
                wdata = a;
            end
            op_br: begin
                target = c;
                cond   = 1'b1;
            end
            op_brr: begin
                target = ex_pc + c;
                cond   = 1'b1;
            end
            op_brri: begin
                target = ex_pc + b;
                cond   = 1'b1;
            end
            op_brnz: begin
                target = c;
                cond   = (a != '0);
            end
            op_brgt: begin
                target = c;
                cond   = ($signed(a) > $signed(b));
            end
            default: ;
        endcase
    end

    assign take = ex_valid_op && cond;
    assign halt = ex_valid_op && (ex_op == op_priv);

    // ################################################################
    // EX/MEM register
    // ################################################################
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            {mem_reg_write, mem_read, mem_write, branch_taken, hlt} <= '0;
        else if (branch_taken)
            {mem_reg_write, mem_read, mem_write, branch_taken, hlt} <= '0;  // Squash EX slot
        else
            {mem_reg_write, mem_read, mem_write, branch_taken, hlt} <=
                {ex_reg_write, ex_mem_read, ex_mem_write, take, halt};
    end

    always_ff @(posedge clk) begin
        mem_result <= result;
        mem_addr   <= addr;
        mem_wdata  <= wdata;
        mem_rd     <= ex_rd;
        branch_pc  <= target;
    end

endmodule

// ==== verilog/tinker_memory.sv ====
//####################################################################
// Little-endian byte memory, instruction and data ports, no latency
// Addresses wrap at mem_bytes; program load works only during reset
//####################################################################

`timescale 1ns/10ps

module tinker_memory #(
    parameter int mem_bytes = 65536
) (
    input  logic               clk,
    input  logic               reset,
    input  tinker_pkg::word_t  fetch_pc,
    input  tinker_pkg::word_t  mem_addr,
    input  tinker_pkg::word_t  mem_wdata,
    input  logic               mem_read,
    input  logic               mem_write,
    input  tinker_pkg::word_t  mem_result,
    input  logic               load_en,
    input  tinker_pkg::word_t  load_addr,
    input  tinker_pkg::word_t  load_data,
    output tinker_pkg::inst_t  inst,
    output tinker_pkg::word_t  wb_data
);
    import tinker_pkg::*;

    localparam int aw = $clog2(mem_bytes);

    logic [7:0]    mem_array [mem_bytes];
    logic [aw-1:0] iaddr;
    logic [aw-1:0] daddr;
    logic [aw-1:0] waddr;
    word_t         rdata;
    word_t         wdata;
    logic          we;

    assign iaddr = fetch_pc[aw-1:0];
    assign daddr = mem_addr[aw-1:0];

    // Load port owns the write path while the pipeline is held
    assign we    = reset ? load_en : mem_write;
    assign waddr = reset ? load_addr[aw-1:0] : daddr;
    assign wdata = reset ? load_data : mem_wdata;

    always_comb begin
        for (int i = 0; i < 4; i++)
            inst[8*i +: 8] = mem_array[iaddr + aw'(i)];
        for (int i = 0; i < 8; i++)
            rdata[8*i +: 8] = mem_array[daddr + aw'(i)];
    end

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < 8; i++)
                mem_array[waddr + aw'(i)] <= wdata[8*i +: 8];
        end
    end

    assign wb_data = mem_read ? rdata : mem_result;    // Load data or ALU result

endmodule

// ==== verilog/tinker_core.sv ====
//####################################################################
// Four-stage Tinker core; never stalls, taken branch squashes three
// Hold reset while loading the program through load_en
//####################################################################

`timescale 1ns/10ps

module tinker_core #(
    parameter tinker_pkg::word_t reset_pc  = 64'h2000,
    parameter int                mem_bytes = 65536
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   load_en,
    input  tinker_pkg::word_t      load_addr,
    input  tinker_pkg::word_t      load_data,     // Written as 8 bytes
    output logic                   hlt,
    output logic                   retire_en,
    output tinker_pkg::reg_addr_t  retire_rd,
    output tinker_pkg::word_t      retire_data
);
    import tinker_pkg::*;

    // Fetch and decode
    word_t     fetch_pc;
    word_t     de_pc;
    inst_t     inst;
    inst_t     de_inst;
    reg_addr_t rs, rt, rd;
    word_t     rs_data, rt_data, rd_data;

    // DE/EX
    word_t     ex_pc, ex_a, ex_b, ex_c, ex_literal;
    opcode_t   ex_op;
    reg_addr_t ex_rd, ex_rs, ex_rt;
    logic      ex_reg_write, ex_mem_read, ex_mem_write, ex_valid_op;

    // EX/MEM and write-back
    word_t     mem_result, mem_addr, mem_wdata, branch_pc, wb_data;
    reg_addr_t mem_rd;
    logic      mem_reg_write, mem_read, mem_write, branch_taken;

    tinker_fetch #(.reset_pc(reset_pc)) u_fetch (.*);

    tinker_regfile u_regfile (
        .write_en   (mem_reg_write),
        .write_rd   (mem_rd),
        .write_data (wb_data),
        .*
    );

    tinker_decode u_decode (.*);

    tinker_execute u_execute (.*);

    tinker_memory #(.mem_bytes(mem_bytes)) u_memory (.*);

    // Retire trace is the register write port itself
    assign retire_en   = mem_reg_write;
    assign retire_rd   = mem_rd;
    assign retire_data = wb_data;

endmodule

// ==== test/tinker_model.svh ====
//####################################################################
// Random program generator and instruction-level reference model
// Programs come in groups of four, so branches land on group starts
//####################################################################

inst_t     prog [256];
int        prog_len = 0;
word_t     dmem [data_words];
reg_addr_t exp_rd [$];
word_t     exp_data [$];
reg_addr_t recent [3];                      // Last three destinations
opcode_t   alu_ops [16] = '{op_add, op_addi, op_sub, op_subi, op_mul, op_div, op_and, op_or,
                            op_xor, op_not, op_shftr, op_shftri, op_shftl, op_shftli,
                            op_mov_reg, op_mov_lit};

localparam reg_addr_t zero_reg  = 5'd0;
localparam reg_addr_t scratch_a = 5'd24;
localparam reg_addr_t data_reg  = 5'd25;
localparam reg_addr_t code_reg  = 5'd26;
localparam reg_addr_t scratch_b = 5'd27;

function automatic int rnd(int n);
    return int'($unsigned($random(seed)) % $unsigned(n));
endfunction

// Pattern for the preloaded data area
function automatic word_t fill_word(word_t addr);
    return {~addr[31:0], addr[31:0] ^ addr[63:32] ^ 32'h9e37_79b9};
endfunction

function automatic inst_t enc(opcode_t op, reg_addr_t rd, reg_addr_t rs, reg_addr_t rt,
                              int lit);
    return {op, rd, rs, rt, 12'(lit)};
endfunction

// Destinations skip the reserved r24 to r27
function automatic reg_addr_t pick_rd();
    int r;
    r = rnd(28);
    if (r >= 24)
        r = r + 4;
    return reg_addr_t'(r);
endfunction

function automatic reg_addr_t pick_src();
    if (rnd(2) == 1)
        return recent[2'(rnd(3))];          // Close dependency
    return reg_addr_t'(rnd(32));
endfunction

function automatic int jump_index(word_t target);
    return int'((target - reset_pc) >> 2);
endfunction

task automatic emit(inst_t i);
    prog[8'(prog_len)] = i;
    prog_len++;
endtask

task automatic push_recent(reg_addr_t rd);
    recent[2] = recent[1];
    recent[1] = recent[0];
    recent[0] = rd;
endtask

task automatic emit_alu();
    reg_addr_t rd;
    rd = pick_rd();
    emit(enc(alu_ops[4'(rnd(16))], rd, pick_src(), pick_src(), rnd(4096)));
    push_recent(rd);
endtask

// ###################################################################
// Program generator
// ###################################################################
task automatic make_program();
    int        kind;
    int        tgt;
    int        imm;
    int        off;
    reg_addr_t rd;
    opcode_t   bop;
    prog   = '{default: '0};
    recent = '{default: '0};
    emit(enc(op_mov_lit, code_reg, zero_reg, zero_reg, 'h200));
    emit(enc(op_shftli, code_reg, zero_reg, zero_reg, 4));      // Code base 0x2000
    emit(enc(op_mov_lit, data_reg, zero_reg, zero_reg, 'h800));
    emit(enc(op_shftli, data_reg, zero_reg, zero_reg, 4));      // Data base 0x8000
    for (int g = 1; g <= groups; g++) begin
        kind = rnd(8);
        imm  = 8 * rnd(16);
        off  = 8 * rnd(16);
        tgt  = 4 * (g + 1 + rnd(3));        // Start of a later group
        if (tgt > 4 * (groups + 1))
            tgt = 4 * (groups + 1);
        case (kind)
            0: begin
                emit(enc(op_mov_reg, scratch_a, data_reg, zero_reg, 0));
                emit(enc(op_addi, scratch_a, zero_reg, zero_reg, imm));
                rd = pick_rd();
                emit(enc(op_mov_mem, rd, scratch_a, zero_reg, off));
                push_recent(rd);
                emit_alu();
            end
            1: begin                        // Store, then load the same word
                emit(enc(op_mov_reg, scratch_b, data_reg, zero_reg, 0));
                emit(enc(op_addi, scratch_b, zero_reg, zero_reg, imm));
                emit(enc(op_mov_str, scratch_b, pick_src(), zero_reg, off));
                rd = pick_rd();
                emit(enc(op_mov_mem, rd, scratch_b, zero_reg, off));
                push_recent(rd);
            end
            2: begin
                bop = (rnd(3) == 0) ? op_br : ((rnd(2) == 0) ? op_brnz : op_brgt);
                emit(enc(op_mov_reg, scratch_b, code_reg, zero_reg, 0));
                emit(enc(op_addi, scratch_b, zero_reg, zero_reg, 4 * tgt));
                emit(enc(bop, scratch_b, pick_src(), pick_src(), 0));
                emit_alu();
            end
            3: begin
                emit(enc(op_sub, scratch_b, code_reg, code_reg, 0));
                emit(enc(op_addi, scratch_b, zero_reg, zero_reg, 4 * (tgt - prog_len - 1)));
                emit(enc(op_brr, scratch_b, zero_reg, zero_reg, 0));
                emit_alu();
            end
            4: begin
                emit_alu();
                emit(enc(op_brri, zero_reg, zero_reg, zero_reg, 4 * (tgt - prog_len)));
                emit_alu();
                emit_alu();
            end
            default: repeat (4) emit_alu();
        endcase
    end
    emit(enc(op_priv, zero_reg, zero_reg, zero_reg, 0));       // Halt
endtask

// ###################################################################
// Reference model, one instruction at a time
// ###################################################################
task automatic run_model();
    word_t     r [32];
    word_t     a, b, c, res, lit, here;
    int        ix;
    inst_t     i;
    opcode_t   op;
    reg_addr_t rd;
    logic      wr;
    r = '{default: '0};
    for (int k = 0; k < data_words; k++)
        dmem[5'(k)] = fill_word(data_base + word_t'(8 * k));
    ix = 0;
    while (ix < prog_len) begin
        i    = prog[8'(ix)];
        op   = opcode_t'(i[31:27]);
        rd   = i[26:22];
        a    = r[i[21:17]];
        b    = r[i[16:12]];
        c    = r[rd];
        lit  = word_t'(i[11:0]);
        here = reset_pc + word_t'(4 * ix);
        ix++;
        res  = '0;
        wr   = !(op inside {op_mov_str, op_br, op_brr, op_brri, op_brnz, op_brgt, op_priv});
        case (op)
            op_add:     res = a + b;
            op_addi:    res = c + lit;
            op_sub:     res = a - b;
            op_subi:    res = c - lit;
            op_mul:     res = word_t'($signed(a) * $signed(b));
            op_div:     res = (b == '0) ? '0 : word_t'($signed(a) / $signed(b));
            op_and:     res = a & b;
            op_or:      res = a | b;
            op_xor:     res = a ^ b;
            op_not:     res = ~a;
            op_shftr:   res = a >> b[5:0];
            op_shftri:  res = c >> lit[5:0];
            op_shftl:   res = a << b[5:0];
            op_shftli:  res = c << lit[5:0];
            op_mov_reg: res = a;
            op_mov_lit: res = {c[63:12], lit[11:0]};
            op_mov_mem: res = dmem[5'((a + lit - data_base) >> 3)];
            op_mov_str: dmem[5'((c + lit - data_base) >> 3)] = a;
            op_br:      ix = jump_index(c);
            op_brr:     ix = jump_index(here + c);
            op_brri:    ix = jump_index(here + lit);
            op_brnz: begin
                if (a != '0)
                    ix = jump_index(c);
            end
            op_brgt: begin
                if ($signed(a) > $signed(b))
                    ix = jump_index(c);
            end
            op_priv:    return;
            default: ;
        endcase
        if (wr) begin
            r[rd] = res;
            exp_rd.push_back(rd);
            exp_data.push_back(res);
        end
    end
endtask

// ==== test/tinker_tb.sv ====
//####################################################################
// Random program on the core, retired register writes checked in order
// Program and data area are loaded while reset is held
//####################################################################

`timescale 1ns/10ps

module tinker_tb;
    import tinker_pkg::*;

    localparam word_t reset_pc        = 64'h2000;
    localparam word_t data_base       = 64'h8000;
    localparam int    data_words      = 32;
    localparam int    groups          = 50;     // Four instructions each
    localparam int    reset_cycles    = 10;
    localparam int    cycles_per_inst = 40;

    logic      clk = 1'b0;
    logic      reset;
    logic      load_en;
    word_t     load_addr;
    word_t     load_data;
    logic      hlt;
    logic      retire_en;
    reg_addr_t retire_rd;
    word_t     retire_data;
    int        seed;
    int        load_cycles = 0;
    int        writes = 0;

    `include "tinker_model.svh"

    tinker_core #(.reset_pc(reset_pc), .mem_bytes(65536)) DUT (.*);

    always #2 clk = ~clk;

    task automatic fail_run(string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    // ################################################################
    // Program load during reset
    // ################################################################
    initial begin
        reset     = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        seed      = 80537;
        make_program();
        run_model();
        load_cycles = (prog_len + 1) / 2 + data_words;
        for (int w = 0; w < (prog_len + 1) / 2; w++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= reset_pc + word_t'(8 * w);
            load_data <= {prog[8'(2 * w + 1)], prog[8'(2 * w)]};    // Lower address in low half
        end
        for (int w = 0; w < data_words; w++) begin
            @(posedge clk);
            load_addr <= data_base + word_t'(8 * w);
            load_data <= fill_word(data_base + word_t'(8 * w));
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

    // Watchdog
    initial begin
        wait (load_cycles > 0);
        repeat (load_cycles + reset_cycles + cycles_per_inst * prog_len) @(posedge clk);
        fail_run("Timeout, hlt never rose before the cycle limit");
    end

    // ################################################################
    // Retire and halt checks, sampled mid-cycle
    // ################################################################
    always @(negedge clk) begin
        if (!reset && retire_en) begin
            assert (exp_rd.size() > 0)
                else fail_run($sformatf("Write to r%0d retired after the last expected write",
                                        retire_rd));
            assert (retire_rd == exp_rd[0])
                else fail_run($sformatf("CHECK FAILED retire_rd: got 0x%h, expected 0x%h",
                                        retire_rd, exp_rd[0]));
            assert (retire_data == exp_data[0])
                else fail_run($sformatf("CHECK FAILED retire_data: got 0x%h, expected 0x%h",
                                        retire_data, exp_data[0]));
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
            writes++;
        end
        if (!reset && hlt) begin
            if (exp_rd.size() == 0) begin
                $display("Halt after %0d register writes", writes);
                $display("TESTBENCH PASSED");
                $finish;
            end else begin
                fail_run($sformatf("Halt came with %0d expected register writes missing",
                                   exp_rd.size()));
            end
        end
    end

endmodule

// ==== filelist.f ====
+incdir+test
verilog/tinker_pkg.sv
verilog/tinker_fetch.sv
verilog/tinker_regfile.sv
verilog/tinker_decode.sv
verilog/tinker_execute.sv
verilog/tinker_memory.sv
verilog/tinker_core.sv
test/tinker_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the Tinker core testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --timing --timescale 1ns/10ps \
    -f filelist.f --top-module tinker_tb -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtinker_tb > "$log" 2>&1
status=$?
cat "$log"

if grep -q "TESTBENCH FAILED" "$log"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
